// File: build.f
logic/video_pkg.sv
logic/video_sync.sv
logic/video_mode.sv
logic/video_fetch.sv
logic/video_render.sv
logic/video_out.sv
logic/video_top.sv
verification/video_sva.sv
verification/video_tb.sv

// File: Bender.yml
package:
  name: video_subsystem

sources:
  # RTL, package first
  - logic/video_pkg.sv
  - logic/video_sync.sv
  - logic/video_mode.sv
  - logic/video_fetch.sv
  - logic/video_render.sv
  - logic/video_out.sv
  - logic/video_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - verification/video_sva.sv
      - verification/video_tb.sv

// File: verification/video_tb.sv
// video testbench: DRAM model, reference colour model and per-pixel frame checker
module video_tb;

	import video_pkg::*;

	// small raster so that a frame is short
	localparam int h_pix    = 32;
	localparam int h_border = 4;
	localparam int h_sync   = 4;
	localparam int v_pix    = 8;
	localparam int v_border = 2;
	localparam int v_sync   = 2;

	localparam int h_total     = h_sync + 2*h_border + h_pix;
	localparam int v_total     = v_sync + 2*v_border + v_pix;
	localparam int frame_clk   = 4 * h_total * v_total;
	localparam int last_frame  = 5;
	localparam int cycle_limit = 6 * frame_clk + 400;

	logic               clk;
	logic               rst_n;
	logic [cidx_w-1:0]  border;
	logic [7:0]         vpage;
	logic [7:0]         vconfig;
	logic [cidx_w-1:0]  pal_addr;
	logic [3*dac_w-1:0] pal_data;
	logic               pal_we;
	logic               video_strobe;
	logic [vword_w-1:0] video_data;
	logic [dac_w-1:0]   vred;
	logic [dac_w-1:0]   vgrn;
	logic [dac_w-1:0]   vblu;
	logic               hsync;
	logic               vsync;
	logic               csync;
	logic               int_start;
	logic [vaddr_w-1:0] video_addr;
	logic               video_go;

	logic [3*dac_w-1:0] pal_model [16];
	logic               exp_mode;
	logic [7:0]         exp_page;
	logic [cidx_w-1:0]  exp_border;
	bit                 colour_on = 1'b0;
	bit                 setup_done = 1'b0;
	int                 errors = 0;
	int                 checks = 0;
	int                 cycles = 0;
	int                 int_count = 0;
	int                 frame_no = -1;
	int                 line_no = -1;
	int                 pix_no = -1;

	video_top #(
		.h_pix    (h_pix    ),
		.h_border (h_border ),
		.h_sync   (h_sync   ),
		.v_pix    (v_pix    ),
		.v_border (v_border ),
		.v_sync   (v_sync   )
	) i_dut (
		.clk          (clk          ),
		.rst_n        (rst_n        ),
		.vred         (vred         ),
		.vgrn         (vgrn         ),
		.vblu         (vblu         ),
		.hsync        (hsync        ),
		.vsync        (vsync        ),
		.csync        (csync        ),
		.border       (border       ),
		.vpage        (vpage        ),
		.vconfig      (vconfig      ),
		.pal_addr     (pal_addr     ),
		.pal_data     (pal_data     ),
		.pal_we       (pal_we       ),
		.int_start    (int_start    ),
		.video_strobe (video_strobe ),
		.video_data   (video_data   ),
		.video_addr   (video_addr   ),
		.video_go     (video_go     )
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory contents, one word per address
	function automatic logic [vword_w-1:0] dram_word(input logic [vaddr_w-1:0] addr);
		return addr[vword_w-1:0] ^ 16'ha5c3;
	endfunction

	// colour at raster position (x, y) for one frame's config and palette
	function automatic logic [3*dac_w-1:0] expected_rgb(
		input int                 x,
		input int                 y,
		input logic               mode,
		input logic [7:0]         page,
		input logic [cidx_w-1:0]  brd,
		input logic [3*dac_w-1:0] pal [16]
	);
		int                 col;
		int                 row;
		logic [vaddr_w-1:0] addr;
		video_word_t        w;
		logic [cidx_w-1:0]  idx;
		if (x < h_sync || y < v_sync)
			return '0;
		col = x - (h_sync + h_border);
		row = y - (v_sync + v_border);
		idx = brd;
		if (col >= 0 && col < h_pix && row >= 0 && row < v_pix) begin
			if (mode == mode_attr) begin
				addr = (vaddr_w'(page) << page_shift) + vaddr_w'(row * (h_pix / 8) + col / 8);
				w = dram_word(addr);
				idx = w.attr.bitmap[7 - col % 8] ? w.attr.ink : w.attr.paper;
			end else begin
				addr = (vaddr_w'(page) << page_shift) + vaddr_w'(row * (h_pix / 4) + col / 4);
				w = dram_word(addr);
				idx = w.gfx[3 - col % 4];
			end
		end
		return pal[idx];
	endfunction

	function automatic int total_errors();
		return errors + i_dut.i_sva.fails;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s at frame %0d line %0d pixel %0d: got %h, expected %h",
				name, frame_no, line_no, pix_no, got, exp);
		end
	endtask

	task automatic write_palette();
		for (int i = 0; i < 16; i++) begin
			pal_addr = 4'(i);
			pal_data = 6'($urandom);
			pal_we = 1'b1;
			pal_model[i] = pal_data;
			@(negedge clk);
		end
		pal_we = 1'b0;
	endtask

	// reserved vconfig bits get random values
	task automatic apply_config(input logic mode, input logic [7:0] page,
			input logic [cidx_w-1:0] brd);
		vconfig = {7'($urandom), mode};
		vpage = page;
		border = brd;
		@(negedge clk);
	endtask

	task automatic wait_position(input int frame, input int line);
		while (!(frame_no == frame && line_no == line))
			@(posedge clk);
		@(negedge clk);
	endtask

	initial begin
		void'($urandom(32'h5e93));
		rst_n = 1'b0;
		border = '0;
		vpage = '0;
		vconfig = '0;
		pal_addr = '0;
		pal_data = '0;
		pal_we = 1'b0;
		repeat (4) @(negedge clk);
		// outputs while reset is held
		compare_value("hsync", hsync, 1'b1);
		compare_value("vsync", vsync, 1'b1);
		compare_value("csync", csync, 1'b1);
		compare_value("int_start", int_start, 1'b0);
		compare_value("video_go", video_go, 1'b0);
		compare_value("rgb", {vred, vgrn, vblu}, 6'd0);
		rst_n = 1'b1;
		write_palette();
		apply_config(mode_gfx4, 8'($urandom), 4'($urandom));
		setup_done = 1'b1;
		// changes in mid frame, seen from the next frame on
		wait_position(1, 6);
		apply_config(mode_attr, 8'($urandom), 4'($urandom));
		wait_position(2, 6);
		apply_config(mode_gfx4, 8'($urandom), 4'($urandom));
		// new palette while the output is blanked in vertical sync
		wait_position(3, 0);
		write_palette();
		wait_position(3, 6);
		apply_config(mode_attr, 8'($urandom), 4'($urandom));
		wait_position(last_frame, 0);
		$display("checks: %0d, errors: %0d", checks, total_errors());
		if (total_errors() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// answers each request once, after 1 to 6 clk
	initial begin : dram_model
		int                 delay;
		int                 read_frame;
		int                 read_no;
		logic [vaddr_w-1:0] addr_exp;
		video_strobe = 1'b0;
		video_data = '0;
		read_frame = -1;
		read_no = 0;
		forever begin
			@(negedge clk);
			video_strobe = 1'b0;
			if (rst_n && video_go) begin
				delay = 1 + int'($urandom % 6);
				repeat (delay - 1) @(negedge clk);
				// rows lie back to back, so read n of a frame is at page base plus n
				if (frame_no != read_frame) begin
					read_frame = frame_no;
					read_no = 0;
				end
				addr_exp = (vaddr_w'(exp_page) << page_shift) + vaddr_w'(read_no);
				compare_value("video_addr", video_addr, addr_exp);
				read_no++;
				video_data = dram_word(video_addr);
				video_strobe = 1'b1;
			end
		end
	end

	always @(negedge clk) begin
		if (rst_n && int_start)
			int_count++;
	end

	initial begin : frame_checker
		logic [3*dac_w-1:0] rgb_exp;
		wait (rst_n === 1'b1);
		// first hsync fall after reset is line 0 of frame 0
		do
			@(negedge clk);
		while (hsync !== 1'b0);
		frame_no = 0;
		line_no = 0;
		pix_no = 0;
		forever begin
			if (pix_no == 0 && line_no == 0) begin
				exp_mode = vconfig[0];
				exp_page = vpage;
				exp_border = border;
				colour_on = setup_done;
			end
			compare_value("hsync", hsync, pix_no >= h_sync);
			compare_value("vsync", vsync, line_no >= v_sync);
			compare_value("csync", csync, (pix_no >= h_sync) && (line_no >= v_sync));
			if (colour_on) begin
				rgb_exp = expected_rgb(pix_no, line_no, exp_mode, exp_page, exp_border,
					pal_model);
				compare_value("rgb", {vred, vgrn, vblu}, rgb_exp);
			end
			if (pix_no == 2 && line_no == 0)
				compare_value("int_start count", int_count, frame_no + 1);
			repeat (4) @(negedge clk);
			pix_no++;
			if (pix_no == h_total) begin
				pix_no = 0;
				line_no++;
				if (line_no == v_total) begin
					line_no = 0;
					frame_no++;
				end
			end
		end
	end

	initial begin : watchdog
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: frame %0d was not reached within %0d clock cycles",
			last_frame, cycle_limit);
		$display("checks: %0d, errors: %0d", checks, total_errors() + 1);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verification/video_sva.sv
// video assertions: sync widths, frame interrupt and DRAM request rules
module video_sva #(
	parameter int h_sync = 32
) (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          hsync,
	input logic                          vsync,
	input logic                          csync,
	input logic                          int_start,
	input logic                          line_start,
	input logic                          video_go,
	input logic                          video_strobe,
	input logic [video_pkg::vaddr_w-1:0] video_addr,
	input logic [video_pkg::vaddr_w-1:0] words_per_line
);

	import video_pkg::*;

	int                 fails = 0;
	logic [vaddr_w-1:0] reads;

	// words delivered since the start of the line
	always_ff @(posedge clk) begin
		if (!rst_n)
			reads <= '0;
		else if (line_start)
			reads <= '0;
		else if (video_strobe && video_go)
			reads <= reads + 1'b1;
	end

	// four clk per pixel
	hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(hsync) |-> ##(4*h_sync) $rose(hsync))
		else begin
			fails++;
			$error("hsync low time differs from %0d pixels", h_sync);
		end

	csync_and: assert property (@(posedge clk) disable iff (!rst_n)
		csync == (hsync && vsync))
		else begin
			fails++;
			$error("csync is not the AND of hsync and vsync");
		end

	int_on_vsync: assert property (@(posedge clk) disable iff (!rst_n)
		int_start == $fell(vsync))
		else begin
			fails++;
			$error("int_start does not match the vsync fall");
		end

	addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		video_go && !video_strobe |=> video_go && $stable(video_addr))
		else begin
			fails++;
			$error("video request dropped or address moved before the strobe");
		end

	read_limit: assert property (@(posedge clk) disable iff (!rst_n)
		reads <= words_per_line)
		else begin
			fails++;
			$error("more words read than one line holds");
		end

endmodule

// sync outputs and fetch signals as seen in the top level
bind video_top video_sva #(
	.h_sync (h_sync)
) i_sva (
	.clk            (clk            ),
	.rst_n          (rst_n          ),
	.hsync          (hsync          ),
	.vsync          (vsync          ),
	.csync          (csync          ),
	.int_start      (int_start      ),
	.line_start     (line_start     ),
	.video_go       (video_go       ),
	.video_strobe   (video_strobe   ),
	.video_addr     (video_addr     ),
	.words_per_line (words_per_line )
);

// File: logic/video_top.sv
// video top: raster sync, frame config, DRAM fetch, render and palette output
module video_top #(
	parameter int h_pix    = 256,
	parameter int h_border = 32,
	parameter int h_sync   = 32,
	parameter int v_pix    = 192,
	parameter int v_border = 24,
	parameter int v_sync   = 4
) (
	input  logic                           clk,
	input  logic                           rst_n,

	// video DAC
	output logic [video_pkg::dac_w-1:0]    vred,
	output logic [video_pkg::dac_w-1:0]    vgrn,
	output logic [video_pkg::dac_w-1:0]    vblu,

	// syncs
	output logic                           hsync,
	output logic                           vsync,
	output logic                           csync,

	// config, latched every frame
	input  logic [video_pkg::cidx_w-1:0]   border,
	input  logic [7:0]                     vpage,
	input  logic [7:0]                     vconfig,

	// CPU palette write
	input  logic [video_pkg::cidx_w-1:0]   pal_addr,
	input  logic [3*video_pkg::dac_w-1:0]  pal_data,
	input  logic                           pal_we,

	output logic                           int_start,

	// DRAM
	input  logic                           video_strobe,
	input  logic [video_pkg::vword_w-1:0]  video_data,
	output logic [video_pkg::vaddr_w-1:0]  video_addr,
	output logic                           video_go
);

	import video_pkg::*;

	localparam int vcnt_w = $clog2(v_sync + 2*v_border + v_pix);

	logic               pix_ce;
	logic [vcnt_w-1:0]  vcnt;
	logic               active;
	logic               line_start;
	logic               frame_start;
	logic               blank;
	logic               render_mode;
	logic [vaddr_w-1:0] page_base;
	logic [cidx_w-1:0]  border_idx;
	logic [vaddr_w-1:0] words_per_line;
	logic               word_valid;
	video_word_t        word_data;
	logic               word_take;
	logic [cidx_w-1:0]  pix_idx;

	video_sync #(
		.h_pix    (h_pix    ),
		.h_border (h_border ),
		.h_sync   (h_sync   ),
		.v_pix    (v_pix    ),
		.v_border (v_border ),
		.v_sync   (v_sync   )
	) video_sync (
		.clk          (clk          ),
		.rst_n        (rst_n        ),
		.pix_ce       (pix_ce       ),
		.hcnt         (             ),
		.vcnt         (vcnt         ),
		.active       (active       ),
		.line_start   (line_start   ),
		.frame_start  (frame_start  ),
		.blank        (blank        ),
		.hsync        (hsync        ),
		.vsync        (vsync        ),
		.csync        (csync        ),
		.int_start    (int_start    )
	);

	video_mode #(
		.h_pix (h_pix)
	) video_mode (
		.clk            (clk            ),
		.rst_n          (rst_n          ),
		.frame_start    (frame_start    ),
		.vconfig        (vconfig        ),
		.vpage          (vpage          ),
		.border         (border         ),
		.render_mode    (render_mode    ),
		.page_base      (page_base      ),
		.border_idx     (border_idx     ),
		.words_per_line (words_per_line )
	);

	video_fetch #(
		.h_pix    (h_pix    ),
		.v_pix    (v_pix    ),
		.v_border (v_border ),
		.v_sync   (v_sync   )
	) video_fetch (
		.clk            (clk            ),
		.rst_n          (rst_n          ),
		.line_start     (line_start     ),
		.vcnt           (vcnt           ),
		.render_mode    (render_mode    ),
		.page_base      (page_base      ),
		.words_per_line (words_per_line ),
		.video_strobe   (video_strobe   ),
		.video_data     (video_data     ),
		.word_take      (word_take      ),
		.video_addr     (video_addr     ),
		.video_go       (video_go       ),
		.word_valid     (word_valid     ),
		.word_data      (word_data      )
	);

	video_render video_render (
		.clk          (clk          ),
		.rst_n        (rst_n        ),
		.pix_ce       (pix_ce       ),
		.active       (active       ),
		.render_mode  (render_mode  ),
		.border_idx   (border_idx   ),
		.word_valid   (word_valid   ),
		.word_data    (word_data    ),
		.word_take    (word_take    ),
		.pix_idx      (pix_idx      )
	);

	video_out video_out (
		.clk       (clk       ),
		.rst_n     (rst_n     ),
		.pix_ce    (pix_ce    ),
		.blank     (blank     ),
		.pix_idx   (pix_idx   ),
		.pal_addr  (pal_addr  ),
		.pal_data  (pal_data  ),
		.pal_we    (pal_we    ),
		.vred      (vred      ),
		.vgrn      (vgrn      ),
		.vblu      (vblu      )
	);

endmodule

// File: logic/video_out.sv
// video out: writable palette, sync blanking and registered DAC outputs
module video_out (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           pix_ce,
	input  logic                           blank,
	input  logic [video_pkg::cidx_w-1:0]   pix_idx,
	input  logic [video_pkg::cidx_w-1:0]   pal_addr,
	input  logic [3*video_pkg::dac_w-1:0]  pal_data,
	input  logic                           pal_we,
	output logic [video_pkg::dac_w-1:0]    vred,
	output logic [video_pkg::dac_w-1:0]    vgrn,
	output logic [video_pkg::dac_w-1:0]    vblu
);

	import video_pkg::*;

	localparam int pal_depth = 2 ** cidx_w;

	logic [3*dac_w-1:0] pal [pal_depth];
	logic [3*dac_w-1:0] rgb;

	// palette comes up black
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < pal_depth; i++)
				pal[i] <= '0;
		end else if (pal_we) begin
			pal[pal_addr] <= pal_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rgb <= '0;
		else if (pix_ce)
			rgb <= blank ? '0 : pal[pix_idx];
	end

	// rrggbb
	assign vred = rgb[3*dac_w-1:2*dac_w];
	assign vgrn = rgb[2*dac_w-1:dac_w];
	assign vblu = rgb[dac_w-1:0];

endmodule

// File: logic/video_render.sv
// video render: per-pixel decode of screen words into palette indices, border outside
module video_render (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         pix_ce,
	input  logic                         active,
	input  logic                         render_mode,
	input  logic [video_pkg::cidx_w-1:0] border_idx,
	input  logic                         word_valid,
	input  video_pkg::video_word_t       word_data,
	output logic                         word_take,
	output logic [video_pkg::cidx_w-1:0] pix_idx
);

	import video_pkg::*;

	video_word_t cur;
	logic [2:0]  pix_sel;
	logic [2:0]  last_sel;
	logic        load;

	// palette index of pixel sel within one word
	function automatic logic [cidx_w-1:0] word_pixel(
		input video_word_t w,
		input logic        mode,
		input logic [2:0]  sel
	);
		logic [cidx_w-1:0] idx;
		if (mode == mode_attr)
			idx = w.attr.bitmap[3'd7 - sel] ? w.attr.ink : w.attr.paper;
		else
			idx = w.gfx[2'd3 - sel[1:0]];
		return idx;
	endfunction

	assign last_sel  = (render_mode == mode_attr) ? 3'd7 : 3'd3;
	assign load      = active && (pix_sel == 3'd0);
	assign word_take = pix_ce && load && word_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_sel <= '0;
			pix_idx <= '0;
		end else if (pix_ce) begin
			if (!active) begin
				pix_sel <= '0;
				pix_idx <= border_idx;
			end else if (load) begin
				// an empty buffer here means an underrun, show border and retry
				pix_sel <= word_valid ? 3'd1 : 3'd0;
				pix_idx <= word_valid ? word_pixel(word_data, render_mode, 3'd0)
				                      : border_idx;
			end else begin
				pix_sel <= (pix_sel == last_sel) ? 3'd0 : pix_sel + 3'd1;
				pix_idx <= word_pixel(cur, render_mode, pix_sel);
			end
		end
	end

	// rest of the word after its first pixel
	always_ff @(posedge clk) begin
		if (word_take)
			cur <= word_data;
	end

endmodule

// File: logic/video_fetch.sv
// video fetch: DRAM word address counter, read request and two-word prefetch buffer
module video_fetch #(
	parameter int h_pix    = 256,
	parameter int v_pix    = 192,
	parameter int v_border = 24,
	parameter int v_sync   = 4
) (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       line_start,
	input  logic [$clog2(v_sync+2*v_border+v_pix)-1:0] vcnt,
	input  logic                                       render_mode,
	input  logic [video_pkg::vaddr_w-1:0]              page_base,
	input  logic [video_pkg::vaddr_w-1:0]              words_per_line,
	input  logic                                       video_strobe,
	input  logic [video_pkg::vword_w-1:0]              video_data,
	input  logic                                       word_take,
	output logic [video_pkg::vaddr_w-1:0]              video_addr,
	output logic                                       video_go,
	output logic                                       word_valid,
	output video_pkg::video_word_t                     word_data
);

	import video_pkg::*;

	localparam int vcnt_w     = $clog2(v_sync + 2*v_border + v_pix);
	localparam int v_act_beg  = v_sync + v_border;
	localparam int gfx4_shift = $clog2(h_pix / 4);
	localparam int attr_shift = $clog2(h_pix / 8);

	logic [vcnt_w-1:0]  row;
	logic               line_act;
	logic [vaddr_w-1:0] row_start;
	logic [vaddr_w-1:0] remain;
	logic               push;
	logic               pop;
	logic               wr_ptr;
	logic               rd_ptr;
	logic [1:0]         count;
	video_word_t        fifo [2];

	assign row      = vcnt - vcnt_w'(v_act_beg);
	assign line_act = (vcnt >= v_act_beg) && (vcnt < v_act_beg + v_pix);

	// line lengths are powers of two, so row times length is a shift
	assign row_start = page_base + (vaddr_w'(row) <<
		((render_mode == mode_attr) ? attr_shift : gfx4_shift));

	assign push = video_strobe && video_go;
	assign pop  = word_take && word_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			video_addr <= '0;
			remain     <= '0;
		end else if (line_start && line_act) begin
			video_addr <= row_start;
			remain     <= words_per_line;
		end else if (push) begin
			video_addr <= video_addr + 1'b1;
			remain     <= remain - 1'b1;
		end
	end

	// only drops after a strobe, so the address holds while requested
	assign video_go = (remain != '0) && (count != 2'd2);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= video_data;
	end

	assign word_valid = (count != 2'd0);
	assign word_data  = fifo[rd_ptr];

endmodule

// File: logic/video_mode.sv
// video mode: per-frame latch of mode, page and border, and line length decode
module video_mode #(
	parameter int h_pix = 256
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          frame_start,
	input  logic [7:0]                    vconfig,
	input  logic [7:0]                    vpage,
	input  logic [video_pkg::cidx_w-1:0]  border,
	output logic                          render_mode,
	output logic [video_pkg::vaddr_w-1:0] page_base,
	output logic [video_pkg::cidx_w-1:0]  border_idx,
	output logic [video_pkg::vaddr_w-1:0] words_per_line
);

	import video_pkg::*;

	// words per active line for each mode
	localparam int gfx4_words = h_pix / 4;
	localparam int attr_words = h_pix / 8;

	// config only changes between frames
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			render_mode <= mode_gfx4;
			page_base   <= '0;
			border_idx  <= '0;
		end else if (frame_start) begin
			// vconfig bits 7:1 are reserved
			render_mode <= vconfig[0];
			page_base   <= vaddr_w'(vpage) << page_shift;
			border_idx  <= border;
		end
	end

	assign words_per_line = (render_mode == mode_attr) ? vaddr_w'(attr_words)
	                                                   : vaddr_w'(gfx4_words);

endmodule

// File: logic/video_sync.sv
// video sync: pixel phase divider, raster counters, syncs, blanking and frame interrupt
module video_sync #(
	parameter int h_pix    = 256,
	parameter int h_border = 32,
	parameter int h_sync   = 32,
	parameter int v_pix    = 192,
	parameter int v_border = 24,
	parameter int v_sync   = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic pix_ce,
	output logic [$clog2(h_sync+2*h_border+h_pix)-1:0] hcnt,
	output logic [$clog2(v_sync+2*v_border+v_pix)-1:0] vcnt,
	output logic active,
	output logic line_start,
	output logic frame_start,
	output logic blank,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic int_start
);

	localparam int h_total   = h_sync + 2*h_border + h_pix;
	localparam int v_total   = v_sync + 2*v_border + v_pix;
	localparam int h_act_beg = h_sync + h_border;
	localparam int v_act_beg = v_sync + v_border;

	logic [1:0] phase;
	logic h_act;
	logic v_act;
	logic hs_raw;
	logic vs_raw;
	logic hs_d1;
	logic vs_d1;

	// four clk per pixel
	always_ff @(posedge clk) begin
		if (!rst_n)
			phase <= '0;
		else
			phase <= phase + 2'd1;
	end

	assign pix_ce = (phase == 2'd3);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (pix_ce) begin
			if (hcnt == h_total - 1) begin
				hcnt <= '0;
				if (vcnt == v_total - 1)
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	assign h_act  = (hcnt >= h_act_beg) && (hcnt < h_act_beg + h_pix);
	assign v_act  = (vcnt >= v_act_beg) && (vcnt < v_act_beg + v_pix);
	assign active = h_act && v_act;

	// high outside the sync periods
	assign hs_raw = (hcnt >= h_sync);
	assign vs_raw = (vcnt >= v_sync);

	assign line_start  = pix_ce && (hcnt == '0);
	assign frame_start = line_start && (vcnt == '0);

	// two pixel delay, same as render plus palette stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hs_d1 <= 1'b1;
			vs_d1 <= 1'b1;
			hsync <= 1'b1;
			vsync <= 1'b1;
			csync <= 1'b1;
		end else if (pix_ce) begin
			hs_d1 <= hs_raw;
			vs_d1 <= vs_raw;
			hsync <= hs_d1;
			vsync <= vs_d1;
			csync <= hs_d1 && vs_d1;
		end
	end

	// first delay stage lines up with the index entering the palette
	assign blank = !(hs_d1 && vs_d1);

	// pulse on the edge where vsync goes low
	always_ff @(posedge clk) begin
		if (!rst_n)
			int_start <= 1'b0;
		else
			int_start <= pix_ce && vsync && !vs_d1;
	end

endmodule

// File: logic/video_pkg.sv
// video package: shared widths, render mode codes and the screen word layout
package video_pkg;

	// DRAM side
	localparam int vaddr_w = 21;
	localparam int vword_w = 16;

	// palette index and per-gun DAC width
	localparam int cidx_w = 4;
	localparam int dac_w  = 2;

	// render mode, taken from vconfig bit 0
	localparam logic mode_gfx4 = 1'b0;
	localparam logic mode_attr = 1'b1;

	// word address bits below the page number
	localparam int page_shift = 13;

	// one DRAM screen word, read either as 4bpp pixels or as bitmap plus attribute
	typedef union packed {
		// leftmost pixel in the top nibble
		logic [3:0][cidx_w-1:0] gfx;
		struct packed {
			logic [cidx_w-1:0] paper;
			logic [cidx_w-1:0] ink;
			logic [7:0]        bitmap;
		} attr;
	} video_word_t;

endpackage
